//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - verilog/fetch_pkg.sv
  - verilog/mem_bus_if.sv
  - verilog/ifu_l1i.sv
  - verilog/lsu_port.sv
  - verilog/bus_arbiter.sv
  - verilog/sram_mem.sv
  - verilog/fetch_top.sv
  - target: test
    files:
      - test/fetch_checker.sv
      - test/fetch_tb.sv

//--- tb.f
verilog/fetch_pkg.sv
verilog/mem_bus_if.sv
verilog/ifu_l1i.sv
verilog/lsu_port.sv
verilog/bus_arbiter.sv
verilog/sram_mem.sv
verilog/fetch_top.sv
test/fetch_checker.sv
test/fetch_tb.sv

//--- test/fetch_checker.sv
`default_nettype none

module fetch_checker (
  input logic clk,
  input logic rst,
  input logic fetch_en_i,
  input logic inst_valid_i,
  input logic next_ready_i,
  input logic npc_valid_i,
  input logic [fetch_pkg::XLEN-1:0] npc_i,
  input logic [fetch_pkg::XLEN-1:0] inst_i,
  input logic [fetch_pkg::XLEN-1:0] pc_i,
  input logic load_i,
  input logic store_i,
  input logic [fetch_pkg::XLEN-1:0] ls_addr_i,
  input logic [fetch_pkg::XLEN-1:0] ls_wdata_i,
  input logic ls_busy_i,
  input logic load_valid_i,
  input logic [fetch_pkg::XLEN-1:0] load_data_i,
  input logic done_i,
  output int error_count_o
);

  localparam int T_FETCH = 0;
  localparam int T_PC = 1;
  localparam int T_STALL = 2;
  localparam int T_BP = 3;
  localparam int T_LS = 4;
  localparam int T_FENCE = 5;
  localparam int N_TESTS = 6;
  localparam int WIDX_W = $clog2(fetch_pkg::MEM_WORDS);

  // memory image built from the stores seen on the load/store port
  logic [fetch_pkg::XLEN-1:0] model_mem [fetch_pkg::MEM_WORDS];
  logic [fetch_pkg::MEM_WORDS-1:0] rewritten;
  int checks [N_TESTS];
  int errors [N_TESTS];
  int err_total = 0;
  logic [fetch_pkg::XLEN-1:0] expect_pc;
  logic [fetch_pkg::XLEN-1:0] held_pc;
  logic [fetch_pkg::XLEN-1:0] held_inst;
  logic stall_pend;
  logic hold_pend;
  logic load_pend;
  logic busy_pend;
  logic [WIDX_W-1:0] load_idx;

  assign error_count_o = err_total;

  function automatic string test_name(input int t);
    case (t)
      T_FETCH: return "fetch_data";
      T_PC: return "pc_sequence";
      T_STALL: return "branch_stall";
      T_BP: return "back_pressure";
      T_LS: return "load_store";
      default: return "fence_i_coherence";
    endcase
  endfunction

  function automatic logic [WIDX_W-1:0] word_of(input logic [fetch_pkg::XLEN-1:0] addr);
    return addr[WIDX_W+1:2];
  endfunction

  function automatic logic is_control_inst(input logic [fetch_pkg::XLEN-1:0] word);
    return (word[6:0] == fetch_pkg::OP_JAL) || (word[6:0] == fetch_pkg::OP_JALR) ||
           (word[6:0] == fetch_pkg::OP_BRANCH) || (word[6:0] == fetch_pkg::OP_SYSTEM) ||
           (word == fetch_pkg::INST_FENCE_I);
  endfunction

  task automatic fail_value(input int t, input string what,
                            input logic [fetch_pkg::XLEN-1:0] exp_v,
                            input logic [fetch_pkg::XLEN-1:0] act_v);
    errors[t]++;
    err_total++;
    $display("error %s (%s) at %0t: expected 0x%08h, actual 0x%08h",
             test_name(t), what, $time, exp_v, act_v);
  endtask

  task automatic fail_plain(input int t, input string msg);
    errors[t]++;
    err_total++;
    $display("%s: %s at %0t", test_name(t), msg, $time);
  endtask

  always @(posedge clk) begin
    logic [WIDX_W-1:0] idx;
    int t;
    if (rst) begin
      expect_pc = fetch_pkg::PC_INIT;
      stall_pend = 1'b0;
      hold_pend = 1'b0;
      load_pend = 1'b0;
      busy_pend = 1'b0;
      rewritten = '0;
    end else begin
      // busy rises the cycle after an accepted strobe
      if (busy_pend) begin
        checks[T_LS]++;
        busy_pend = 1'b0;
        if (!ls_busy_i) begin
          fail_plain(T_LS, "ls_busy_o did not rise after a load or store strobe");
        end
      end
      if (load_valid_i) begin
        checks[T_LS]++;
        if (!load_pend) begin
          fail_plain(T_LS, "load_valid_o pulsed with no load outstanding");
        end else if (load_data_i !== model_mem[load_idx]) begin
          fail_value(T_LS, "load_data_o", model_mem[load_idx], load_data_i);
        end
        if (ls_busy_i) begin
          fail_plain(T_LS, "ls_busy_o still high when load_valid_o pulsed");
        end
        load_pend = 1'b0;
      end
      if (!ls_busy_i && (store_i || load_i)) begin
        busy_pend = 1'b1;
        if (store_i) begin
          model_mem[word_of(ls_addr_i)] = ls_wdata_i;
          if (fetch_en_i && ls_addr_i < 32'h800) begin
            rewritten[word_of(ls_addr_i)] = 1'b1;
          end
        end else begin
          load_pend = 1'b1;
          load_idx = word_of(ls_addr_i);
        end
      end

      if (hold_pend) begin
        checks[T_BP]++;
        hold_pend = 1'b0;
        if (!inst_valid_i) begin
          fail_plain(T_BP, "inst_valid_o dropped while next_ready_i was low");
        end else if (pc_i !== held_pc) begin
          fail_value(T_BP, "pc_o", held_pc, pc_i);
        end else if (inst_i !== held_inst) begin
          fail_value(T_BP, "inst_o", held_inst, inst_i);
        end
      end

      if (stall_pend) begin
        if (inst_valid_i) begin
          fail_plain(T_STALL, "inst_valid_o went high before npc_valid_i");
        end
        if (npc_valid_i) begin
          checks[T_STALL]++;
          stall_pend = 1'b0;
          expect_pc = npc_i;
        end
      end else if (inst_valid_i && next_ready_i) begin
        checks[T_PC]++;
        if (pc_i !== expect_pc) begin
          fail_value(T_PC, "pc_o", expect_pc, pc_i);
        end
        idx = word_of(pc_i);
        t = rewritten[idx] ? T_FENCE : T_FETCH;
        checks[t]++;
        if (inst_i !== model_mem[idx]) begin
          fail_value(t, "inst_o", model_mem[idx], inst_i);
        end
        if (is_control_inst(model_mem[idx])) begin
          stall_pend = 1'b1;
        end else begin
          expect_pc = expect_pc + 32'd4;
        end
      end else if (inst_valid_i) begin
        hold_pend = 1'b1;
        held_pc = pc_i;
        held_inst = inst_i;
      end
    end
  end

  initial begin
    int t;
    int total;
    total = 0;
    for (t = 0; t < N_TESTS; t++) begin
      checks[t] = 0;
      errors[t] = 0;
    end
    wait (done_i === 1'b1);
    if (load_pend) begin
      fail_plain(T_LS, "a load never returned load_valid_o");
    end
    for (t = 0; t < N_TESTS; t++) begin
      $display("%s: %0d checks, %0d errors", test_name(t), checks[t], errors[t]);
      total += checks[t];
    end
    $display("all tests: %0d checks, %0d errors", total, err_total);
  end

endmodule

`default_nettype wire

//--- test/fetch_tb.sv
`default_nettype none

module fetch_tb;

  localparam int N_FETCH = 400;
  localparam int CLK_PERIOD = 100;
  localparam int PROG_WORDS = 512;
  localparam int PRELOAD_CYCLES = fetch_pkg::MEM_WORDS * 8;
  localparam int WATCHDOG_CYCLES = N_FETCH * 2000 + PRELOAD_CYCLES;

  logic clk = 1'b0;
  logic rst;
  logic fetch_en;
  logic next_ready;
  logic npc_valid;
  logic load;
  logic store;
  logic [fetch_pkg::XLEN-1:0] npc;
  logic [fetch_pkg::XLEN-1:0] ls_addr;
  logic [fetch_pkg::XLEN-1:0] ls_wdata;
  logic inst_valid;
  logic ls_busy;
  logic load_valid;
  logic [fetch_pkg::XLEN-1:0] inst;
  logic [fetch_pkg::XLEN-1:0] pc;
  logic [fetch_pkg::XLEN-1:0] load_data;

  logic done;
  logic waiting;
  logic fetch_done;
  int error_count;
  int accepts;
  int npc_delay;
  int rewrite_cnt;

  always #(CLK_PERIOD / 2) clk = ~clk;

  fetch_top fetch_top_inst (
    .clk(clk),
    .rst(rst),
    .fetch_en_i(fetch_en),
    .next_ready_i(next_ready),
    .npc_valid_i(npc_valid),
    .load_i(load),
    .store_i(store),
    .npc_i(npc),
    .ls_addr_i(ls_addr),
    .ls_wdata_i(ls_wdata),
    .inst_valid_o(inst_valid),
    .ls_busy_o(ls_busy),
    .load_valid_o(load_valid),
    .inst_o(inst),
    .pc_o(pc),
    .load_data_o(load_data)
  );

  fetch_checker checker_inst (
    .clk(clk),
    .rst(rst),
    .fetch_en_i(fetch_en),
    .inst_valid_i(inst_valid),
    .next_ready_i(next_ready),
    .npc_valid_i(npc_valid),
    .npc_i(npc),
    .inst_i(inst),
    .pc_i(pc),
    .load_i(load),
    .store_i(store),
    .ls_addr_i(ls_addr),
    .ls_wdata_i(ls_wdata),
    .ls_busy_i(ls_busy),
    .load_valid_i(load_valid),
    .load_data_i(load_data),
    .done_i(done),
    .error_count_o(error_count)
  );

  function automatic logic is_control(input logic [fetch_pkg::XLEN-1:0] word);
    logic [6:0] op;
    op = word[6:0];
    return (op == fetch_pkg::OP_JAL) || (op == fetch_pkg::OP_JALR) ||
           (op == fetch_pkg::OP_BRANCH) || (op == fetch_pkg::OP_SYSTEM) ||
           (word == fetch_pkg::INST_FENCE_I);
  endfunction

  // roughly one word in eight transfers control
  function automatic logic [fetch_pkg::XLEN-1:0] random_inst();
    logic [fetch_pkg::XLEN-1:0] word;
    int sel;
    word = $urandom;
    sel = $urandom % 32;
    case (sel)
      0: word = fetch_pkg::INST_FENCE_I;
      1: word[6:0] = fetch_pkg::OP_JAL;
      2: word[6:0] = fetch_pkg::OP_JALR;
      3: word[6:0] = word[7] ? fetch_pkg::OP_BRANCH : fetch_pkg::OP_SYSTEM;
      default: word[6:0] = 7'b0010011;
    endcase
    return word;
  endfunction

  // one load or store, returns once the port is idle again
  task automatic ls_access(input logic is_store, input int widx,
                           input logic [fetch_pkg::XLEN-1:0] data);
    store <= is_store;
    load <= !is_store;
    ls_addr <= widx * 4;
    ls_wdata <= data;
    @(posedge clk);
    store <= 1'b0;
    load <= 1'b0;
    @(posedge clk);
    while (ls_busy) begin
      @(posedge clk);
    end
  endtask

  task automatic preload_memory();
    logic [fetch_pkg::XLEN-1:0] word;
    for (int w = 0; w < fetch_pkg::MEM_WORDS; w++) begin
      if (w < PROG_WORDS - 1) begin
        word = random_inst();
      end else if (w == PROG_WORDS - 1) begin
        // last program word jumps so fetch never runs into data
        word = {25'd0, fetch_pkg::OP_JAL};
      end else begin
        word = $urandom;
      end
      ls_access(1'b1, w, word);
    end
  endtask

  task automatic drive_fetch();
    while (accepts < N_FETCH) begin
      @(posedge clk);
      npc_valid <= 1'b0;
      next_ready <= ($urandom % 4) != 0;
      if (waiting) begin
        if (npc_delay > 0) begin
          npc_delay = npc_delay - 1;
        end else if (rewrite_cnt == 0) begin
          npc_valid <= 1'b1;
          npc <= ($urandom % PROG_WORDS) * 4;
          waiting = 1'b0;
        end
      end else if (inst_valid && next_ready) begin
        accepts = accepts + 1;
        if (is_control(inst)) begin
          waiting = 1'b1;
          npc_delay = $urandom % 6;
          if (inst == fetch_pkg::INST_FENCE_I) begin
            rewrite_cnt = 8;
          end
        end
      end
    end
    fetch_done = 1'b1;
  endtask

  // data region traffic, plus program rewrites after a fence.i
  task automatic drive_lsu_traffic();
    int widx;
    while (!fetch_done) begin
      if (rewrite_cnt > 0) begin
        ls_access(1'b1, $urandom % (PROG_WORDS - 1), random_inst());
        rewrite_cnt = rewrite_cnt - 1;
      end else begin
        repeat ($urandom % 6) @(posedge clk);
        widx = PROG_WORDS + ($urandom % PROG_WORDS);
        if ($urandom % 2) begin
          ls_access(1'b1, widx, $urandom);
        end else begin
          ls_access(1'b0, widx, '0);
        end
      end
    end
  endtask

  initial begin
    void'($urandom(34));
    rst = 1'b1;
    fetch_en = 1'b0;
    next_ready = 1'b0;
    npc_valid = 1'b0;
    load = 1'b0;
    store = 1'b0;
    npc = '0;
    ls_addr = '0;
    ls_wdata = '0;
    done = 1'b0;
    waiting = 1'b0;
    fetch_done = 1'b0;
    accepts = 0;
    npc_delay = 0;
    rewrite_cnt = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    preload_memory();
    fetch_en <= 1'b1;
    fork
      drive_fetch();
      drive_lsu_traffic();
    join
    repeat (4) @(posedge clk);
    done <= 1'b1;
    repeat (2) @(posedge clk);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/bus_arbiter.sv
`default_nettype none

module bus_arbiter (
  input logic clk,
  input logic rst,
  mem_bus_if.responder ifu_s,
  mem_bus_if.responder lsu_s,
  mem_bus_if.requester mem_m
);

  logic busy_q;
  // 1 when the lsu owns the bus
  logic owner_q;

  always_comb begin
    if (owner_q) begin
      mem_m.req = busy_q && lsu_s.req;
      mem_m.we = lsu_s.we;
      mem_m.addr = lsu_s.addr;
      mem_m.wdata = lsu_s.wdata;
    end else begin
      mem_m.req = busy_q && ifu_s.req;
      mem_m.we = ifu_s.we;
      mem_m.addr = ifu_s.addr;
      mem_m.wdata = ifu_s.wdata;
    end
  end

  assign ifu_s.rdata = mem_m.rdata;
  assign lsu_s.rdata = mem_m.rdata;
  assign ifu_s.rvalid = busy_q && !owner_q && mem_m.rvalid;
  assign lsu_s.rvalid = busy_q && owner_q && mem_m.rvalid;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      owner_q <= 1'b0;
    end else if (!busy_q) begin
      // lsu wins ties
      if (lsu_s.req) begin
        busy_q <= 1'b1;
        owner_q <= 1'b1;
      end else if (ifu_s.req) begin
        busy_q <= 1'b1;
        owner_q <= 1'b0;
      end
    end else if (mem_m.rvalid) begin
      busy_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  localparam int XLEN = 32;
  localparam int MEM_WORDS = 1024;
  localparam logic [XLEN-1:0] PC_INIT = 32'h0000_0000;

  // l1i geometry
  localparam int L1I_LINES = 4;
  localparam int L1I_LINE_WORDS = 2;
  localparam int IDX_W = 2;
  localparam int OFF_W = 1;
  localparam int TAG_W = 27;

  // control opcodes
  localparam logic [6:0] OP_JAL = 7'b1101111;
  localparam logic [6:0] OP_JALR = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [XLEN-1:0] INST_FENCE_I = 32'h0000_100F;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] idx;
    logic [OFF_W-1:0] off;
    logic [1:0] byte_off;
  } fetch_fields_t;

  // same word seen raw or as cache fields
  typedef union packed {
    logic [XLEN-1:0] raw;
    fetch_fields_t f;
  } fetch_addr_u;

endpackage

`default_nettype wire

//--- verilog/fetch_top.sv
`default_nettype none

module fetch_top (
  input logic clk,
  input logic rst,
  input logic fetch_en_i,
  input logic next_ready_i,
  input logic npc_valid_i,
  input logic load_i,
  input logic store_i,
  input logic [fetch_pkg::XLEN-1:0] npc_i,
  input logic [fetch_pkg::XLEN-1:0] ls_addr_i,
  input logic [fetch_pkg::XLEN-1:0] ls_wdata_i,
  output logic inst_valid_o,
  output logic ls_busy_o,
  output logic load_valid_o,
  output logic [fetch_pkg::XLEN-1:0] inst_o,
  output logic [fetch_pkg::XLEN-1:0] pc_o,
  output logic [fetch_pkg::XLEN-1:0] load_data_o
);

  mem_bus_if ifu_bus ();
  mem_bus_if lsu_bus ();
  mem_bus_if mem_bus ();

  ifu_l1i ifu_l1i_inst (
    .clk(clk),
    .rst(rst),
    .fetch_en_i(fetch_en_i),
    .next_ready_i(next_ready_i),
    .npc_valid_i(npc_valid_i),
    .npc_i(npc_i),
    .inst_o(inst_o),
    .pc_o(pc_o),
    .inst_valid_o(inst_valid_o),
    .bus(ifu_bus.requester)
  );

  lsu_port lsu_port_inst (
    .clk(clk),
    .rst(rst),
    .load_i(load_i),
    .store_i(store_i),
    .addr_i(ls_addr_i),
    .wdata_i(ls_wdata_i),
    .busy_o(ls_busy_o),
    .load_valid_o(load_valid_o),
    .load_data_o(load_data_o),
    .bus(lsu_bus.requester)
  );

  bus_arbiter bus_arbiter_inst (
    .clk(clk),
    .rst(rst),
    .ifu_s(ifu_bus.responder),
    .lsu_s(lsu_bus.responder),
    .mem_m(mem_bus.requester)
  );

  sram_mem sram_mem_inst (
    .clk(clk),
    .rst(rst),
    .bus(mem_bus.responder)
  );

endmodule

`default_nettype wire

//--- verilog/ifu_l1i.sv
`default_nettype none

module ifu_l1i (
  input logic clk,
  input logic rst,
  input logic fetch_en_i,
  input logic next_ready_i,
  input logic npc_valid_i,
  input logic [fetch_pkg::XLEN-1:0] npc_i,
  output logic [fetch_pkg::XLEN-1:0] inst_o,
  output logic [fetch_pkg::XLEN-1:0] pc_o,
  output logic inst_valid_o,
  mem_bus_if.requester bus
);

  fetch_pkg::fetch_addr_u pc_q;
  fetch_pkg::fetch_addr_u refill_addr;

  logic [fetch_pkg::XLEN-1:0] l1i_data [fetch_pkg::L1I_LINES][fetch_pkg::L1I_LINE_WORDS];
  logic [fetch_pkg::TAG_W-1:0] l1i_tag [fetch_pkg::L1I_LINES];
  logic [fetch_pkg::L1I_LINES-1:0] l1i_valid;

  // 0 idle, 1 first word, 2 second word
  logic [1:0] state_q;
  logic req_q;
  logic stall_q;

  logic hit;
  logic accept;
  logic [6:0] opcode;
  logic is_fence_i;
  logic is_ctrl;

  assign hit = (state_q == 2'd0) && l1i_valid[pc_q.f.idx] &&
               (l1i_tag[pc_q.f.idx] == pc_q.f.tag);

  assign inst_o = l1i_data[pc_q.f.idx][pc_q.f.off];
  assign pc_o = pc_q.raw;
  assign inst_valid_o = hit && !stall_q;
  assign accept = inst_valid_o && next_ready_i;

  assign opcode = inst_o[6:0];
  assign is_fence_i = (inst_o == fetch_pkg::INST_FENCE_I);
  assign is_ctrl = (opcode == fetch_pkg::OP_JAL) || (opcode == fetch_pkg::OP_JALR) ||
                   (opcode == fetch_pkg::OP_BRANCH) || (opcode == fetch_pkg::OP_SYSTEM) ||
                   is_fence_i;

  // even word first, then odd word of the line
  always_comb begin
    refill_addr = pc_q;
    refill_addr.f.off = state_q[1];
    refill_addr.f.byte_off = 2'b00;
  end

  assign bus.req = req_q;
  assign bus.we = 1'b0;
  assign bus.addr = refill_addr.raw;
  assign bus.wdata = '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= 2'd0;
      req_q <= 1'b0;
      l1i_valid <= '0;
    end else begin
      case (state_q)
        2'd0: begin
          if (!hit && !stall_q && fetch_en_i) begin
            state_q <= 2'd1;
            req_q <= 1'b1;
          end
        end
        2'd1: begin
          if (bus.rvalid) begin
            state_q <= 2'd2;
            req_q <= 1'b0;
          end
        end
        2'd2: begin
          if (bus.rvalid) begin
            state_q <= 2'd0;
            req_q <= 1'b0;
            l1i_valid[pc_q.f.idx] <= 1'b1;
          end else if (!req_q) begin
            // one idle cycle between the two reads
            req_q <= 1'b1;
          end
        end
        default: begin
          state_q <= 2'd0;
          req_q <= 1'b0;
        end
      endcase
      if (accept && is_fence_i) begin
        l1i_valid <= '0;
      end
    end
  end

  // line payload
  always_ff @(posedge clk) begin
    if (bus.rvalid && state_q != 2'd0) begin
      l1i_data[pc_q.f.idx][state_q[1]] <= bus.rdata;
      l1i_tag[pc_q.f.idx] <= pc_q.f.tag;
    end
  end

  // pc sequencing and branch stall
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q.raw <= fetch_pkg::PC_INIT;
      stall_q <= 1'b0;
    end else if (stall_q) begin
      if (npc_valid_i) begin
        pc_q.raw <= npc_i;
        stall_q <= 1'b0;
      end
    end else if (accept) begin
      if (is_ctrl) begin
        stall_q <= 1'b1;
      end else begin
        pc_q.raw <= pc_q.raw + 32'd4;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/lsu_port.sv
`default_nettype none

module lsu_port (
  input logic clk,
  input logic rst,
  input logic load_i,
  input logic store_i,
  input logic [fetch_pkg::XLEN-1:0] addr_i,
  input logic [fetch_pkg::XLEN-1:0] wdata_i,
  output logic busy_o,
  output logic load_valid_o,
  output logic [fetch_pkg::XLEN-1:0] load_data_o,
  mem_bus_if.requester bus
);

  logic busy_q;
  logic we_q;
  logic [fetch_pkg::XLEN-1:0] addr_q;
  logic [fetch_pkg::XLEN-1:0] wdata_q;

  assign busy_o = busy_q;
  assign bus.req = busy_q;
  assign bus.we = we_q;
  assign bus.addr = addr_q;
  assign bus.wdata = wdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      load_valid_o <= 1'b0;
    end else begin
      load_valid_o <= busy_q && bus.rvalid && !we_q;
      if (!busy_q && (load_i || store_i)) begin
        busy_q <= 1'b1;
      end else if (bus.rvalid) begin
        busy_q <= 1'b0;
      end
    end
  end

  // request payload and returned data
  always_ff @(posedge clk) begin
    if (!busy_q && (load_i || store_i)) begin
      we_q <= store_i;
      addr_q <= addr_i;
      wdata_q <= wdata_i;
    end
    if (busy_q && bus.rvalid && !we_q) begin
      load_data_o <= bus.rdata;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mem_bus_if.sv
`default_nettype none

interface mem_bus_if;

  logic req;
  logic we;
  logic [fetch_pkg::XLEN-1:0] addr;
  logic [fetch_pkg::XLEN-1:0] wdata;
  logic [fetch_pkg::XLEN-1:0] rdata;
  logic rvalid;

  // holds req and payload until rvalid
  modport requester (
    output req, we, addr, wdata,
    input rdata, rvalid
  );

  modport responder (
    input req, we, addr, wdata,
    output rdata, rvalid
  );

endinterface

`default_nettype wire

//--- verilog/sram_mem.sv
`default_nettype none

module sram_mem (
  input logic clk,
  input logic rst,
  mem_bus_if.responder bus
);

  logic [fetch_pkg::XLEN-1:0] mem [fetch_pkg::MEM_WORDS];
  logic [$clog2(fetch_pkg::MEM_WORDS)-1:0] word_idx;
  logic rvalid_q;
  logic [fetch_pkg::XLEN-1:0] rdata_q;
  logic new_req;

  // word address, byte bits dropped
  assign word_idx = bus.addr[$clog2(fetch_pkg::MEM_WORDS)+1:2];

  // a held req during its own rvalid is not a new one
  assign new_req = bus.req && !rvalid_q;

  assign bus.rvalid = rvalid_q;
  assign bus.rdata = rdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= new_req;
    end
  end

  always_ff @(posedge clk) begin
    if (new_req) begin
      if (bus.we) begin
        mem[word_idx] <= bus.wdata;
      end
      rdata_q <= mem[word_idx];
    end
  end

endmodule

`default_nettype wire
